// File: design/cache_pkg.sv
package cache_pkg;

    // geometry
    localparam int tag_w          = 20;
    localparam int index_w        = 8;
    localparam int num_sets       = 256;
    localparam int words_per_line = 4;
    localparam int num_ways       = 2;

    // one cpu request as held by the lookup stage
    typedef struct packed {
        logic               op;        // 1 = write
        logic [tag_w-1:0]   tag;
        logic [index_w-1:0] index;
        logic [1:0]         word;      // offset[3:2]
        logic [1:0]         byte_off;  // offset[1:0]
        logic [3:0]         wstrb;
        logic [31:0]        wdata;
    } cpu_req_t;

    typedef logic [words_per_line-1:0][31:0] line_t;  // word 0 in the low bits

    typedef struct packed {
        logic [tag_w-1:0] tag;
        logic             valid;
    } tagv_t;

    // what refill needs to know about a miss
    typedef struct packed {
        cpu_req_t         req;
        logic             victim_way;
        logic             victim_dirty;
        logic             victim_valid;
        logic [tag_w-1:0] victim_tag;
        line_t            victim_line;
    } miss_info_t;

    typedef struct packed {
        logic               way;
        logic [1:0]         word;
        logic [index_w-1:0] index;
        logic [3:0]         be;
        logic [31:0]        data;
        logic               en;
    } bank_wr_t;

    typedef struct packed {
        logic [index_w-1:0] index;
        logic               way;
        tagv_t              tagv;
        logic               dirty;
        logic               replace;
        logic               tagv_en;
        logic               dirty_en;
        logic               replace_en;
    } tag_wr_t;

endpackage

// File: design/cache_tag_store.sv
`timescale 1ns/1ps

module cache_tag_store
    import cache_pkg::*;
(
    input  logic                clk,
    input  logic                resetn,
    input  logic [index_w-1:0]  rd_index,
    input  tag_wr_t             lookup_wr,
    input  tag_wr_t             refill_wr,
    output tagv_t [num_ways-1:0] tagv,
    output logic [num_ways-1:0] dirty,
    output logic                replace_way
);

    tag_wr_t wr;

    logic [tag_w-1:0] tag_mem [num_ways][num_sets];

    // per-set state that must come up cleared
    logic [num_ways-1:0][num_sets-1:0] valid_bits;
    logic [num_ways-1:0][num_sets-1:0] dirty_bits;
    logic [num_sets-1:0]               replace_bits;

    logic [num_ways-1:0][tag_w-1:0] rd_tag;
    logic [num_ways-1:0]            rd_valid;

    // refill update has priority over a hit update
    assign wr = (refill_wr.tagv_en | refill_wr.dirty_en | refill_wr.replace_en)
                ? refill_wr : lookup_wr;

    // tag memory, synchronous read
    always_ff @(posedge clk) begin
        if (wr.tagv_en) begin
            tag_mem[wr.way][wr.index] <= wr.tagv.tag;
        end
        for (int w = 0; w < num_ways; w++) begin
            rd_tag[w] <= tag_mem[w][rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits   <= '0;
            dirty_bits   <= '0;
            replace_bits <= '0;
            rd_valid     <= '0;
            dirty        <= '0;
            replace_way  <= 1'b0;
        end else begin
            if (wr.tagv_en) begin
                valid_bits[wr.way][wr.index] <= wr.tagv.valid;
            end
            if (wr.dirty_en) begin
                dirty_bits[wr.way][wr.index] <= wr.dirty;
            end
            if (wr.replace_en) begin
                replace_bits[wr.index] <= wr.replace;
            end

            // sampled in step with the tag read
            for (int w = 0; w < num_ways; w++) begin
                rd_valid[w] <= valid_bits[w][rd_index];
                dirty[w]    <= dirty_bits[w][rd_index];
            end
            replace_way <= replace_bits[rd_index];
        end
    end

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            tagv[w].tag   = rd_tag[w];
            tagv[w].valid = rd_valid[w];
        end
    end

endmodule

// File: design/cache_data_store.sv
`timescale 1ns/1ps

module cache_data_store
    import cache_pkg::*;
(
    input  logic                 clk,
    input  logic [index_w-1:0]   rd_index,
    input  bank_wr_t             lookup_wr,
    input  bank_wr_t             refill_wr,
    output line_t [num_ways-1:0] lines
);

    bank_wr_t wr;

    // one bank per way and word
    logic [31:0] bank [num_ways][words_per_line][num_sets];

    assign wr = refill_wr.en ? refill_wr : lookup_wr;  // refill wins

    always_ff @(posedge clk) begin
        if (wr.en) begin
            for (int b = 0; b < 4; b++) begin
                if (wr.be[b]) begin
                    bank[wr.way][wr.word][wr.index][b*8 +: 8] <= wr.data[b*8 +: 8];
                end
            end
        end
    end

    // whole line of each way, ready in the lookup cycle
    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            for (int k = 0; k < words_per_line; k++) begin
                lines[w][k] <= bank[w][k][rd_index];
            end
        end
    end

endmodule

// File: design/cache_lookup.sv
`timescale 1ns/1ps

module cache_lookup
    import cache_pkg::*;
(
    input  logic                 clk,
    input  logic                 resetn,
    // cpu side
    input  logic                 valid,
    input  logic                 op,
    input  logic [index_w-1:0]   index,
    input  logic [tag_w-1:0]     tag,
    input  logic [3:0]           offset,
    input  logic [3:0]           wstrb,
    input  logic [31:0]          wdata,
    output logic                 addr_ok,
    output logic                 data_ok,
    output logic [31:0]          rdata,
    // stores
    output logic [index_w-1:0]   rd_index,
    input  tagv_t [num_ways-1:0] tagv,
    input  logic [num_ways-1:0]  dirty,
    input  logic                 replace_way,
    input  line_t [num_ways-1:0] lines,
    output bank_wr_t             bank_wr,
    output tag_wr_t              tag_wr,
    // refill side
    input  logic                 busy,
    input  logic                 refill_data_ok,
    input  logic [31:0]          refill_rdata,
    output logic                 miss_valid,
    output miss_info_t           miss_info
);

    cpu_req_t            req;
    logic                held;     // high in the lookup cycle
    logic [num_ways-1:0] way_hit;
    logic                hit;
    logic                hit_way;
    logic                lookup_ok;

    assign addr_ok  = ~held & ~busy;
    assign rd_index = index;  // stores read from the live index

    always_ff @(posedge clk) begin
        if (!resetn) begin
            held <= 1'b0;
        end else begin
            held <= valid & addr_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (valid && addr_ok) begin
            req <= '{op: op, tag: tag, index: index, word: offset[3:2],
                     byte_off: offset[1:0], wstrb: wstrb, wdata: wdata};
        end
    end

    // tag compare
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            way_hit[w] = tagv[w].valid && (tagv[w].tag == req.tag);
        end
    end
    assign hit       = |way_hit;
    assign hit_way   = way_hit[1];
    assign lookup_ok = held & hit;

    // the hit word, or the refill response when that one fires
    assign data_ok = lookup_ok | refill_data_ok;
    assign rdata   = refill_data_ok ? refill_rdata : lines[hit_way][req.word];

    // store hit goes straight into the bank with its strobes
    always_comb begin
        bank_wr.way   = hit_way;
        bank_wr.word  = req.word;
        bank_wr.index = req.index;
        bank_wr.be    = req.wstrb;
        bank_wr.data  = req.wdata;
        bank_wr.en    = lookup_ok & req.op;
    end

    always_comb begin
        tag_wr.index      = req.index;
        tag_wr.way        = hit_way;
        tag_wr.tagv.tag   = req.tag;
        tag_wr.tagv.valid = 1'b1;
        tag_wr.dirty      = 1'b1;
        tag_wr.replace    = ~hit_way;  // point at the other way
        tag_wr.tagv_en    = 1'b0;      // tags only change on refill
        tag_wr.dirty_en   = lookup_ok & req.op;
        tag_wr.replace_en = lookup_ok;
    end

    // miss hand-off with the victim picked by the replace bit
    assign miss_valid = held & ~hit;

    always_comb begin
        miss_info.req          = req;
        miss_info.victim_way   = replace_way;
        miss_info.victim_dirty = dirty[replace_way];
        miss_info.victim_valid = tagv[replace_way].valid;
        miss_info.victim_tag   = tagv[replace_way].tag;
        miss_info.victim_line  = lines[replace_way];
    end

endmodule

// File: design/cache_refill.sv
`timescale 1ns/1ps

module cache_refill
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  logic        miss_valid,
    input  miss_info_t  miss_info,
    output logic        busy,
    // line read
    output logic        rd_req,
    output logic [31:0] rd_addr,
    input  logic        rd_rdy,
    input  logic        ret_valid,
    input  logic        ret_last,
    input  logic [31:0] ret_data,
    // write-back
    output logic        wr_req,
    output logic [31:0] wr_addr,
    output line_t       wr_data,
    input  logic        wr_rdy,
    // store updates and cpu response
    output bank_wr_t    bank_wr,
    output tag_wr_t     tag_wr,
    output logic        refill_data_ok,
    output logic [31:0] refill_rdata
);

    typedef enum logic [1:0] {
        st_idle,
        st_wb,
        st_req,
        st_refill
    } state_t;

    state_t     state;
    miss_info_t mi;
    logic [1:0] beat_cnt;
    logic       beat;
    logic       last_beat;
    logic       store_beat;

    // byte merge of the store data over a returned word
    function automatic logic [31:0] merge_word(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0]  strb);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= st_idle;
            beat_cnt <= 2'd0;
        end else begin
            case (state)
                st_idle: begin
                    if (miss_valid) begin
                        // clean or empty victim skips the write-back
                        if (miss_info.victim_valid && miss_info.victim_dirty) begin
                            state <= st_wb;
                        end else begin
                            state <= st_req;
                        end
                    end
                end
                st_wb: begin
                    if (wr_rdy) begin
                        state <= st_req;
                    end
                end
                st_req: begin
                    if (rd_rdy) begin
                        state    <= st_refill;
                        beat_cnt <= 2'd0;
                    end
                end
                st_refill: begin
                    if (ret_valid) begin
                        beat_cnt <= beat_cnt + 2'd1;
                        if (ret_last) begin
                            state <= st_idle;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && miss_valid) begin
            mi <= miss_info;
        end
    end

    assign busy = (state != st_idle);

    assign wr_req  = (state == st_wb) & wr_rdy;  // wr_rdy seen first
    assign wr_addr = {mi.victim_tag, mi.req.index, 4'b0000};
    assign wr_data = mi.victim_line;

    assign rd_req  = (state == st_req);
    assign rd_addr = {mi.req.tag, mi.req.index, 4'b0000};

    assign beat       = (state == st_refill) & ret_valid;
    assign last_beat  = beat & ret_last;
    assign store_beat = mi.req.op && (beat_cnt == mi.req.word);

    always_comb begin
        bank_wr.way   = mi.victim_way;
        bank_wr.word  = beat_cnt;
        bank_wr.index = mi.req.index;
        bank_wr.be    = 4'hf;
        bank_wr.data  = store_beat ? merge_word(ret_data, mi.req.wdata, mi.req.wstrb)
                                   : ret_data;
        bank_wr.en    = beat;
    end

    // new tag, dirty and replace bits land with the last beat
    always_comb begin
        tag_wr.index      = mi.req.index;
        tag_wr.way        = mi.victim_way;
        tag_wr.tagv.tag   = mi.req.tag;
        tag_wr.tagv.valid = 1'b1;
        tag_wr.dirty      = mi.req.op;
        tag_wr.replace    = ~mi.victim_way;  // toggle
        tag_wr.tagv_en    = last_beat;
        tag_wr.dirty_en   = last_beat;
        tag_wr.replace_en = last_beat;
    end

    // reads answer on their own word, writes once the line is in
    assign refill_data_ok = mi.req.op ? last_beat : (beat && beat_cnt == mi.req.word);
    assign refill_rdata   = ret_data;

endmodule

// File: design/cache.sv
`timescale 1ns/1ps

module cache
    import cache_pkg::*;
(
    input  logic               clk,
    input  logic               resetn,
    // cpu side
    input  logic               valid,
    input  logic               op,
    input  logic [index_w-1:0] index,
    input  logic [tag_w-1:0]   tag,
    input  logic [3:0]         offset,
    input  logic [3:0]         wstrb,
    input  logic [31:0]        wdata,
    output logic               addr_ok,
    output logic               data_ok,
    output logic [31:0]        rdata,
    // memory side
    output logic               rd_req,
    output logic [31:0]        rd_addr,
    input  logic               rd_rdy,
    input  logic               ret_valid,
    input  logic               ret_last,
    input  logic [31:0]        ret_data,
    output logic               wr_req,
    output logic [31:0]        wr_addr,
    output logic [127:0]       wr_data,
    input  logic               wr_rdy
);

    logic [index_w-1:0]   rd_index;
    tagv_t [num_ways-1:0] tagv;
    logic [num_ways-1:0]  dirty;
    logic                 replace_way;
    line_t [num_ways-1:0] lines;
    bank_wr_t             lookup_bank_wr, refill_bank_wr;
    tag_wr_t              lookup_tag_wr, refill_tag_wr;
    logic                 busy, miss_valid, refill_data_ok;
    logic [31:0]          refill_rdata;
    miss_info_t           miss_info;

    cache_lookup u_lookup (
        .clk, .resetn, .valid, .op, .index, .tag, .offset, .wstrb, .wdata,
        .addr_ok, .data_ok, .rdata, .rd_index, .tagv, .dirty, .replace_way, .lines,
        .bank_wr(lookup_bank_wr), .tag_wr(lookup_tag_wr),
        .busy, .refill_data_ok, .refill_rdata, .miss_valid, .miss_info
    );

    cache_refill u_refill (
        .clk, .resetn, .miss_valid, .miss_info, .busy,
        .rd_req, .rd_addr, .rd_rdy, .ret_valid, .ret_last, .ret_data,
        .wr_req, .wr_addr, .wr_data, .wr_rdy,
        .bank_wr(refill_bank_wr), .tag_wr(refill_tag_wr),
        .refill_data_ok, .refill_rdata
    );

    cache_tag_store u_tag_store (
        .clk, .resetn, .rd_index, .lookup_wr(lookup_tag_wr), .refill_wr(refill_tag_wr),
        .tagv, .dirty, .replace_way
    );

    cache_data_store u_data_store (
        .clk, .rd_index, .lookup_wr(lookup_bank_wr), .refill_wr(refill_bank_wr), .lines
    );

endmodule

// File: testbench/tb_cache.sv
`timescale 1ns/1ps

module tb_cache;

    logic         clk = 1'b0;
    logic         resetn;
    logic         valid;
    logic         op;
    logic [7:0]   index;
    logic [19:0]  tag;
    logic [3:0]   offset;
    logic [3:0]   wstrb;
    logic [31:0]  wdata;
    logic         addr_ok;
    logic         data_ok;
    logic [31:0]  rdata;
    logic         rd_req;
    logic [31:0]  rd_addr;
    logic         rd_rdy    = 1'b0;
    logic         ret_valid = 1'b0;
    logic         ret_last  = 1'b0;
    logic [31:0]  ret_data  = '0;
    logic         wr_req;
    logic [31:0]  wr_addr;
    logic [127:0] wr_data;
    logic         wr_rdy    = 1'b0;

    // stimulus table, one entry per stim line
    logic         st_op [$];
    logic [31:0]  st_addr [$];
    logic [3:0]   st_strb [$];
    logic [31:0]  st_data [$];
    logic [31:0]  st_expect [$];
    int           st_test [$];
    int           n_lines;
    logic         loaded = 1'b0;

    // expected cache state: tags, valid, dirty and replace per set
    logic [255:0][1:0][19:0] m_tag;
    logic [255:0][1:0]       m_val;
    logic [255:0][1:0]       m_dirty;
    logic [255:0]            m_repl;
    logic                    exp_miss;
    logic                    exp_wb;
    logic [31:0]             exp_wb_addr;

    logic [31:0] mem [logic [29:0]];   // backing memory, written by write-backs
    logic [31:0] view [logic [29:0]];  // memory as the cpu sees it
    logic [31:0] rnd_state = 32'd85790;
    logic        returning = 1'b0;
    int          beats_done;
    int          rd_count;
    int          wr_count;
    logic [31:0] last_rd_addr;
    logic [31:0] last_wr_addr;
    logic [31:0] wb_word_addr;

    // outputs sampled mid-cycle, acted on at the next edge
    logic         s_rd_ok = 1'b0;
    logic [31:0]  s_rd_addr;
    logic         s_wr = 1'b0;
    logic [31:0]  s_wr_addr;
    logic [127:0] s_wr_data;

    int pending;
    int main_errors;
    int mon_errors;
    int mem_errors;

    cache u_cache (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] pattern_word(input logic [31:0] addr);
        return {2'b00, addr[31:2]} ^ 32'h5a5a0000;  // word address xor fixed tag
    endfunction

    function automatic logic [31:0] backing_word(input logic [31:0] addr);
        if (mem.exists(addr[31:2])) begin
            return mem[addr[31:2]];
        end
        return pattern_word(addr);
    endfunction

    function automatic logic [31:0] view_word(input logic [31:0] addr);
        if (view.exists(addr[31:2])) begin
            return view[addr[31:2]];
        end
        return pattern_word(addr);
    endfunction

    function automatic logic [31:0] apply_strobes(input logic [31:0] old_word,
                                                  input logic [31:0] new_word,
                                                  input logic [3:0]  strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    function automatic int total_errors();
        return main_errors + mon_errors + mem_errors;
    endfunction

    // hit or miss, victim and new replace bit for one accepted request
    task automatic predict_lookup(input logic [19:0] t, input logic [7:0] s, input logic wr_op);
        logic h0;
        logic h1;
        logic v;
        h0 = m_val[s][0] && (m_tag[s][0] == t);
        h1 = m_val[s][1] && (m_tag[s][1] == t);
        exp_miss = !(h0 || h1);
        exp_wb   = 1'b0;
        if (!exp_miss) begin
            m_repl[s] = h0;  // away from the way just hit
            if (wr_op) begin
                m_dirty[s][h1] = 1'b1;
            end
        end else begin
            v = m_repl[s];
            exp_wb        = m_val[s][v] && m_dirty[s][v];
            exp_wb_addr   = {m_tag[s][v], s, 4'h0};
            m_tag[s][v]   = t;
            m_val[s][v]   = 1'b1;
            m_dirty[s][v] = wr_op;
            m_repl[s]     = ~v;
        end
    endtask

    always @(negedge clk) begin
        s_rd_ok   <= rd_req & rd_rdy;
        s_rd_addr <= rd_addr;
        s_wr      <= wr_req;
        s_wr_addr <= wr_addr;
        s_wr_data <= wr_data;
    end

    // memory with random stalls on every handshake
    always @(posedge clk) begin
        if (ret_valid) begin
            beats_done++;
            if (beats_done == 4) begin
                returning = 1'b0;
            end
        end
        if (s_rd_ok) begin
            rd_count++;
            last_rd_addr = s_rd_addr;
            beats_done   = 0;
            returning    = 1'b1;
        end
        if (s_wr) begin
            wr_count++;
            last_wr_addr = s_wr_addr;
            for (int k = 0; k < 4; k++) begin
                wb_word_addr = s_wr_addr + 32'(k * 4);
                if (s_wr_data[k*32 +: 32] !== view_word(wb_word_addr)) begin
                    $display("mismatch at %0t: write-back word %h is %h, expected %h", $time,
                             wb_word_addr, s_wr_data[k*32 +: 32], view_word(wb_word_addr));
                    mem_errors++;
                end
                mem[wb_word_addr[31:2]] = s_wr_data[k*32 +: 32];
            end
        end
        rnd_state = xorshift32(rnd_state);
        rd_rdy <= rnd_state[0] | rnd_state[1];
        wr_rdy <= rnd_state[2] | rnd_state[3];
        if (returning && (rnd_state[4] | rnd_state[5])) begin
            ret_valid <= 1'b1;
            ret_data  <= backing_word(last_rd_addr + 32'(beats_done * 4));
            ret_last  <= (beats_done == 3);
        end else begin
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
        end
    end

    // every data_ok must answer an accepted request
    always @(negedge clk) begin
        if (resetn) begin
            if (data_ok) begin
                if (pending == 0) begin
                    $display("error at %0t: data_ok with no request in flight", $time);
                    mon_errors++;
                end else begin
                    pending--;
                end
            end
            if (valid && addr_ok) begin
                pending++;
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (n_lines * 400 + 50) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", n_lines * 400 + 50);
        $display("=== FAIL ===");
        $finish;
    end

    task automatic run_request(input logic wr_op, input logic [31:0] addr,
                               input logic [3:0] strb, input logic [31:0] data,
                               input logic [31:0] expect_data, input int id);
        int lat;
        int rd_base;
        int wr_base;
        @(posedge clk);
        valid  <= 1'b1;
        op     <= wr_op;
        tag    <= addr[31:12];
        index  <= addr[11:4];
        offset <= addr[3:0];
        wstrb  <= strb;
        wdata  <= data;
        @(negedge clk);
        while (!addr_ok) begin
            @(negedge clk);
        end
        // taken at the coming edge
        predict_lookup(addr[31:12], addr[11:4], wr_op);
        if (wr_op) begin
            view[addr[31:2]] = apply_strobes(view_word(addr), data, strb);
        end
        rd_base = rd_count;
        wr_base = wr_count;
        @(posedge clk);
        valid <= 1'b0;
        lat = 1;
        @(negedge clk);
        while (!data_ok) begin
            @(negedge clk);
            lat++;
        end

        if (!wr_op && rdata !== expect_data) begin
            $display("mismatch at %0t: test %0d read %h gave %h, expected %h", $time, id,
                     addr, rdata, expect_data);
            main_errors++;
        end
        if (exp_miss) begin
            if (rd_count - rd_base != 1) begin
                $display("error at %0t: test %0d expected one line read on a miss, saw %0d",
                         $time, id, rd_count - rd_base);
                main_errors++;
            end else if (last_rd_addr !== {addr[31:4], 4'h0}) begin
                $display("mismatch at %0t: test %0d line read at %h, expected %h", $time, id,
                         last_rd_addr, {addr[31:4], 4'h0});
                main_errors++;
            end
        end else begin
            if (rd_count != rd_base || lat != 1) begin
                $display("error at %0t: test %0d hit took %0d cycles with %0d line reads",
                         $time, id, lat, rd_count - rd_base);
                main_errors++;
            end
        end
        if (wr_count - wr_base != (exp_wb ? 1 : 0)) begin
            $display("error at %0t: test %0d saw %0d write-backs, expected %0d", $time, id,
                     wr_count - wr_base, exp_wb ? 1 : 0);
            main_errors++;
        end else if (exp_wb && last_wr_addr !== exp_wb_addr) begin
            $display("mismatch at %0t: test %0d write-back at %h, expected %h", $time, id,
                     last_wr_addr, exp_wb_addr);
            main_errors++;
        end
    endtask

    initial begin
        int          fd;
        int          n;
        int          f_test;
        int          n_pass;
        int          n_fail;
        int          test_start;
        string       text;
        logic        f_op;
        logic [31:0] f_addr;
        logic [3:0]  f_strb;
        logic [31:0] f_data;
        logic [31:0] f_expect;

        resetn  = 1'b0;
        valid   = 1'b0;
        op      = 1'b0;
        index   = '0;
        tag     = '0;
        offset  = '0;
        wstrb   = '0;
        wdata   = '0;
        m_tag   = '0;
        m_val   = '0;
        m_dirty = '0;
        m_repl  = '0;
        n_pass  = 0;
        n_fail  = 0;

        fd = $fopen("testbench/cache_stim.txt", "r");
        if (fd == 0) begin
            $display("error: could not open the stimulus file");
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(text, fd) == 0) begin
                    break;
                end
                if (text.len() < 2 || text[0] == "#") begin
                    continue;  // comment or blank
                end
                n = $sscanf(text, "%h %h %h %h %h %d", f_op, f_addr, f_strb, f_data,
                            f_expect, f_test);
                if (n == 6) begin
                    st_op.push_back(f_op);
                    st_addr.push_back(f_addr);
                    st_strb.push_back(f_strb);
                    st_data.push_back(f_data);
                    st_expect.push_back(f_expect);
                    st_test.push_back(f_test);
                end
            end
            $fclose(fd);
        end
        n_lines = st_op.size();
        if (n_lines == 0) begin
            $display("error: no stimulus lines were loaded");
            main_errors++;
        end
        loaded = 1'b1;

        repeat (3) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        if (!addr_ok || data_ok || rd_req || wr_req) begin
            $display("error at %0t: outputs not idle after reset", $time);
            main_errors++;
        end

        test_start = total_errors();
        for (int i = 0; i < n_lines; i++) begin
            run_request(st_op[i], st_addr[i], st_strb[i], st_data[i], st_expect[i], st_test[i]);
            if (i + 1 >= n_lines || st_test[i + 1] != st_test[i]) begin
                if (total_errors() == test_start) begin
                    $display("test %0d passed", st_test[i]);
                    n_pass++;
                end else begin
                    $display("test %0d failed", st_test[i]);
                    n_fail++;
                end
                test_start = total_errors();
            end
        end

        $display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, total_errors());
        if (n_fail == 0 && total_errors() == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: testbench/cache_stim.txt
# op addr wstrb wdata expected test, all hex except test in decimal
# op 1 writes with byte strobes (expected unused), op 0 reads and checks expected
0 00001104 0 00000000 5a5a0441 1
0 0000110c 0 00000000 5a5a0443 2
0 00001100 0 00000000 5a5a0440 2
1 00001108 3 deadbeef 00000000 3
0 00001108 0 00000000 5a5abeef 3
1 00001108 8 11223344 00000000 3
0 00001108 0 00000000 115abeef 3
1 00002208 6 cafef00d 00000000 4
0 00002208 0 00000000 5afef082 4
0 00002200 0 00000000 5a5a0880 4
0 00003300 0 00000000 5a5a0cc0 5
0 00004300 0 00000000 5a5a10c0 5
0 00003304 0 00000000 5a5a0cc1 5
0 00005300 0 00000000 5a5a14c0 5
1 0000530c f 0badcafe 00000000 5
0 00003308 0 00000000 5a5a0cc2 5
0 00006304 0 00000000 5a5a18c1 5
0 0000530c 0 00000000 0badcafe 5
0 00007200 0 00000000 5a5a1c80 5
0 00008200 0 00000000 5a5a2080 5
0 00002208 0 00000000 5afef082 5
0 00001108 0 00000000 115abeef 6
1 00001100 1 000000aa 00000000 6
0 00001100 0 00000000 5a5a04aa 6
0 fffff3f0 0 00000000 65a5fcfc 6

// File: cache.f
design/cache_pkg.sv
design/cache_tag_store.sv
design/cache_data_store.sv
design/cache_lookup.sv
design/cache_refill.sv
design/cache.sv
testbench/tb_cache.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?=
FILELIST  ?= cache.f
TOP_TB    ?= tb_cache
TOP_RTL   ?= cache
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP_RTL)

$(BUILD_DIR)/V$(TOP_TB): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP_TB) \
		--Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP_TB) testbench/cache_stim.txt
	./$(BUILD_DIR)/V$(TOP_TB) | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
